//--- include/opu_defs.svh
`ifndef OPU_DEFS_SVH
`define OPU_DEFS_SVH

// width of data words and memory addresses
`define OPU_DATA_W 32

// instruction pointer lives in register 15
`define OPU_REG_IP 15

// memory model depth, addresses wrap modulo this
`define OPU_MEM_WORDS 256

`endif

//--- rtl/opu_pkg.sv
`include "opu_defs.svh"

package opu_pkg;

  typedef logic [`OPU_DATA_W-1:0] data_t;
  typedef logic [3:0] reg_num_t;
  typedef logic [3:0] cmd_code_t;

  // post-update flag, 11 behaves as none
  typedef enum logic [1:0] {
    UPD_NONE     = 2'b00,
    UPD_INC      = 2'b01,
    UPD_DEC      = 2'b10,
    UPD_NONE_ALT = 2'b11
  } upd_e;

  typedef struct packed {
    reg_num_t num;
    logic     ptr;
    upd_e     upd;
  } operand_field_t;

  // layout from msb: code, update flags, pointer flags, register numbers
  typedef struct packed {
    cmd_code_t code;
    upd_e      upd_cond;
    upd_e      upd_d;
    upd_e      upd_s0;
    upd_e      upd_s1;
    logic      ptr_cond;
    logic      ptr_d;
    logic      ptr_s0;
    logic      ptr_s1;
    reg_num_t  num_cond;
    reg_num_t  num_d;
    reg_num_t  num_s0;
    reg_num_t  num_s1;
  } cmd_word_t;

  typedef enum logic [1:0] {
    OWN_FETCH = 2'd0,
    OWN_SLOT  = 2'd1,
    OWN_DST   = 2'd2,
    OWN_NONE  = 2'd3
  } mem_owner_e;

  // register value after its post-update
  function automatic data_t apply_upd(data_t value, upd_e upd);
    case (upd)
      UPD_INC: return value + data_t'(1);
      UPD_DEC: return value - data_t'(1);
      default: return value;
    endcase
  endfunction

  // true when the update needs a writeback
  function automatic logic upd_writes(upd_e upd);
    return (upd == UPD_INC) || (upd == UPD_DEC);
  endfunction

endpackage

//--- rtl/cmd_fetch.sv
`timescale 1ns/1ps
`include "opu_defs.svh"

module cmd_fetch (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  opu_pkg::data_t    reg_base,
  input  logic              grant_done,
  input  opu_pkg::data_t    grant_rdata,
  output logic              req_rd,
  output logic              req_wr,
  output opu_pkg::data_t    req_addr,
  output opu_pkg::data_t    req_wdata,
  output opu_pkg::cmd_word_t cmd,
  output opu_pkg::data_t    ip_next,
  output logic              fetch_done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RD_IP,
    ST_RD_CMD,
    ST_WR_IP
  } state_e;

  state_e state;
  opu_pkg::data_t ip_addr;

  // memory address of register 15
  assign ip_addr = reg_base + opu_pkg::data_t'(`OPU_REG_IP);

  always_ff @(posedge clk) begin
    // request and done lines are single-cycle pulses
    req_rd     <= 1'b0;
    req_wr     <= 1'b0;
    fetch_done <= 1'b0;
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          // start only honoured here
          if (start) begin
            req_rd   <= 1'b1;
            req_addr <= ip_addr;
            state    <= ST_RD_IP;
          end
        end
        ST_RD_IP: begin
          if (grant_done) begin
            // ip value is the command address
            ip_next  <= grant_rdata + opu_pkg::data_t'(1);
            req_rd   <= 1'b1;
            req_addr <= grant_rdata;
            state    <= ST_RD_CMD;
          end
        end
        ST_RD_CMD: begin
          if (grant_done) begin
            cmd       <= grant_rdata;
            req_wr    <= 1'b1;
            req_addr  <= ip_addr;
            req_wdata <= ip_next;
            state     <= ST_WR_IP;
          end
        end
        ST_WR_IP: begin
          if (grant_done) begin
            fetch_done <= 1'b1;
            state      <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- rtl/forward_select.sv
`timescale 1ns/1ps
`include "opu_defs.svh"

module forward_select (
  input  opu_pkg::cmd_word_t cmd,
  input  opu_pkg::data_t     ip_next,
  input  opu_pkg::data_t     cond_reg,
  input  opu_pkg::data_t     src1_reg,
  input  opu_pkg::data_t     src0_reg,
  output logic               cond_fwd,
  output logic               src1_fwd,
  output logic               src0_fwd,
  output logic               dst_fwd,
  output opu_pkg::data_t     cond_fwd_val,
  output opu_pkg::data_t     src1_fwd_val,
  output opu_pkg::data_t     src0_fwd_val,
  output opu_pkg::data_t     dst_fwd_val
);

  localparam opu_pkg::reg_num_t IP_NUM = opu_pkg::reg_num_t'(`OPU_REG_IP);

  // most recent earlier step wins: src0, src1, cond, then ip
  always_comb begin
    cond_fwd     = (cmd.num_cond == IP_NUM);
    cond_fwd_val = ip_next;

    src1_fwd     = 1'b1;
    src1_fwd_val = ip_next;
    if (cmd.num_s1 == cmd.num_cond) src1_fwd_val = cond_reg;
    else if (cmd.num_s1 != IP_NUM) src1_fwd = 1'b0;

    src0_fwd     = 1'b1;
    src0_fwd_val = ip_next;
    if (cmd.num_s0 == cmd.num_s1) src0_fwd_val = src1_reg;
    else if (cmd.num_s0 == cmd.num_cond) src0_fwd_val = cond_reg;
    else if (cmd.num_s0 != IP_NUM) src0_fwd = 1'b0;

    // dst sees all three slots
    dst_fwd     = 1'b1;
    dst_fwd_val = ip_next;
    if (cmd.num_d == cmd.num_s0) dst_fwd_val = src0_reg;
    else if (cmd.num_d == cmd.num_s1) dst_fwd_val = src1_reg;
    else if (cmd.num_d == cmd.num_cond) dst_fwd_val = cond_reg;
    else if (cmd.num_d != IP_NUM) dst_fwd = 1'b0;
  end

endmodule

//--- rtl/operand_slot.sv
`timescale 1ns/1ps

module operand_slot (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   go,
  input  opu_pkg::data_t         base,
  input  opu_pkg::operand_field_t field,
  input  logic                   fwd_hit,
  input  opu_pkg::data_t         fwd_val,
  input  logic                   grant_done,
  input  opu_pkg::data_t         grant_rdata,
  output logic                   req_rd,
  output logic                   req_wr,
  output opu_pkg::data_t         req_addr,
  output opu_pkg::data_t         req_wdata,
  output opu_pkg::data_t         reg_val,
  output opu_pkg::data_t         operand,
  output logic                   slot_done
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_REG,
    ST_GOT,
    ST_RD_PTR,
    ST_UPD,
    ST_WR_UPD
  } state_e;

  state_e state;
  // register value before its own update
  opu_pkg::data_t reg_pre;

  assign reg_val = opu_pkg::apply_upd(reg_pre, field.upd);

  always_ff @(posedge clk) begin
    // addr and data idle at zero so the slots can be or-merged
    req_rd    <= 1'b0;
    req_wr    <= 1'b0;
    req_addr  <= '0;
    req_wdata <= '0;
    slot_done <= 1'b0;
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (go && fwd_hit) begin
            // earlier step already has it, no read
            reg_pre <= fwd_val;
            state   <= ST_GOT;
          end else if (go) begin
            req_rd   <= 1'b1;
            req_addr <= base;
            state    <= ST_RD_REG;
          end
        end
        ST_RD_REG: begin
          if (grant_done) begin
            reg_pre <= grant_rdata;
            state   <= ST_GOT;
          end
        end
        ST_GOT: begin
          if (field.ptr) begin
            // indirect through the pre-update value
            req_rd   <= 1'b1;
            req_addr <= reg_pre;
            state    <= ST_RD_PTR;
          end else begin
            operand <= reg_pre;
            state   <= ST_UPD;
          end
        end
        ST_RD_PTR: begin
          if (grant_done) begin
            operand <= grant_rdata;
            state   <= ST_UPD;
          end
        end
        ST_UPD: begin
          if (opu_pkg::upd_writes(field.upd)) begin
            req_wr    <= 1'b1;
            req_addr  <= base;
            req_wdata <= reg_val;
            state     <= ST_WR_UPD;
          end else begin
            slot_done <= 1'b1;
            state     <= ST_IDLE;
          end
        end
        ST_WR_UPD: begin
          if (grant_done) begin
            slot_done <= 1'b1;
            state     <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- rtl/dst_writer.sv
`timescale 1ns/1ps

module dst_writer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   result_valid,
  input  opu_pkg::data_t         result,
  input  opu_pkg::data_t         base,
  input  opu_pkg::operand_field_t field,
  input  logic                   fwd_hit,
  input  opu_pkg::data_t         fwd_val,
  input  logic                   grant_done,
  input  opu_pkg::data_t         grant_rdata,
  output logic                   req_rd,
  output logic                   req_wr,
  output opu_pkg::data_t         req_addr,
  output opu_pkg::data_t         req_wdata,
  output logic                   done
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_REG,
    ST_GOT,
    ST_WR_PTR,
    ST_WR_LAST
  } state_e;

  state_e state;
  opu_pkg::data_t result_q;
  opu_pkg::data_t reg_pre;

  always_ff @(posedge clk) begin
    req_rd <= 1'b0;
    req_wr <= 1'b0;
    done   <= 1'b0;
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (result_valid) begin
            result_q <= result;
            if (!field.ptr) begin
              // plain register write, update flag ignored
              req_wr    <= 1'b1;
              req_addr  <= base;
              req_wdata <= result;
              state     <= ST_WR_LAST;
            end else if (fwd_hit) begin
              reg_pre <= fwd_val;
              state   <= ST_GOT;
            end else begin
              req_rd   <= 1'b1;
              req_addr <= base;
              state    <= ST_RD_REG;
            end
          end
        end
        ST_RD_REG: begin
          if (grant_done) begin
            reg_pre <= grant_rdata;
            state   <= ST_GOT;
          end
        end
        ST_GOT: begin
          // store result at the pointed-to address
          req_wr    <= 1'b1;
          req_addr  <= reg_pre;
          req_wdata <= result_q;
          state     <= ST_WR_PTR;
        end
        ST_WR_PTR: begin
          if (grant_done && opu_pkg::upd_writes(field.upd)) begin
            req_wr    <= 1'b1;
            req_addr  <= base;
            req_wdata <= opu_pkg::apply_upd(reg_pre, field.upd);
            state     <= ST_WR_LAST;
          end else if (grant_done) begin
            done  <= 1'b1;
            state <= ST_IDLE;
          end
        end
        ST_WR_LAST: begin
          if (grant_done) begin
            done  <= 1'b1;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- rtl/mem_port_mux.sv
`timescale 1ns/1ps

module mem_port_mux (
  input  logic           clk,
  input  logic           rst,
  input  logic           fetch_req_rd,
  input  logic           fetch_req_wr,
  input  opu_pkg::data_t fetch_req_addr,
  input  opu_pkg::data_t fetch_req_wdata,
  input  logic           slot_req_rd,
  input  logic           slot_req_wr,
  input  opu_pkg::data_t slot_req_addr,
  input  opu_pkg::data_t slot_req_wdata,
  input  logic           dst_req_rd,
  input  logic           dst_req_wr,
  input  opu_pkg::data_t dst_req_addr,
  input  opu_pkg::data_t dst_req_wdata,
  input  logic           mem_rd_done,
  input  logic           mem_wr_done,
  input  opu_pkg::data_t mem_rdata,
  output logic           mem_rd,
  output logic           mem_wr,
  output opu_pkg::data_t mem_addr,
  output opu_pkg::data_t mem_wdata,
  output logic           fetch_grant_done,
  output opu_pkg::data_t fetch_grant_rdata,
  output logic           slot_grant_done,
  output opu_pkg::data_t slot_grant_rdata,
  output logic           dst_grant_done,
  output opu_pkg::data_t dst_grant_rdata
);

  opu_pkg::mem_owner_e owner;
  logic any_done;

  assign any_done = mem_rd_done | mem_wr_done;

  // done and data go back to the recorded owner only
  assign fetch_grant_done  = any_done && (owner == opu_pkg::OWN_FETCH);
  assign slot_grant_done   = any_done && (owner == opu_pkg::OWN_SLOT);
  assign dst_grant_done    = any_done && (owner == opu_pkg::OWN_DST);
  assign fetch_grant_rdata = (owner == opu_pkg::OWN_FETCH) ? mem_rdata : '0;
  assign slot_grant_rdata  = (owner == opu_pkg::OWN_SLOT) ? mem_rdata : '0;
  assign dst_grant_rdata   = (owner == opu_pkg::OWN_DST) ? mem_rdata : '0;

  always_ff @(posedge clk) begin
    mem_rd <= 1'b0;
    mem_wr <= 1'b0;
    if (rst) begin
      owner <= opu_pkg::OWN_NONE;
    end else if (fetch_req_rd || fetch_req_wr) begin
      mem_rd    <= fetch_req_rd;
      mem_wr    <= fetch_req_wr;
      mem_addr  <= fetch_req_addr;
      mem_wdata <= fetch_req_wdata;
      owner     <= opu_pkg::OWN_FETCH;
    end else if (slot_req_rd || slot_req_wr) begin
      mem_rd    <= slot_req_rd;
      mem_wr    <= slot_req_wr;
      mem_addr  <= slot_req_addr;
      mem_wdata <= slot_req_wdata;
      owner     <= opu_pkg::OWN_SLOT;
    end else if (dst_req_rd || dst_req_wr) begin
      mem_rd    <= dst_req_rd;
      mem_wr    <= dst_req_wr;
      mem_addr  <= dst_req_addr;
      mem_wdata <= dst_req_wdata;
      owner     <= opu_pkg::OWN_DST;
    end else if (any_done) begin
      // port free again
      owner <= opu_pkg::OWN_NONE;
    end
  end

endmodule

//--- rtl/operand_unit.sv
`timescale 1ns/1ps

module operand_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  opu_pkg::data_t     reg_base,
  input  opu_pkg::data_t     result,
  input  logic               result_valid,
  input  opu_pkg::data_t     mem_rdata,
  input  logic               mem_rd_done,
  input  logic               mem_wr_done,
  output logic               mem_rd,
  output logic               mem_wr,
  output opu_pkg::data_t     mem_addr,
  output opu_pkg::data_t     mem_wdata,
  output opu_pkg::data_t     cond,
  output opu_pkg::data_t     src1,
  output opu_pkg::data_t     src0,
  output opu_pkg::cmd_code_t cmd_code,
  output logic               operands_valid,
  output logic               done
);

  opu_pkg::cmd_word_t cmd;
  opu_pkg::data_t ip_next;
  logic fetch_done;
  logic f_rd, f_wr, f_done;
  opu_pkg::data_t f_addr, f_wdata, f_rdata;

  // merged slot request lines
  logic s_rd, s_wr, s_done;
  opu_pkg::data_t s_addr, s_wdata, s_rdata;
  logic c_rd, c_wr, s1_rd, s1_wr, s0_rd, s0_wr;
  opu_pkg::data_t c_addr, c_wdata, s1_addr, s1_wdata, s0_addr, s0_wdata;
  logic c_done, s1_done;

  logic d_rd, d_wr, d_done;
  opu_pkg::data_t d_addr, d_wdata, d_rdata;

  opu_pkg::operand_field_t c_field, s1_field, s0_field, d_field;
  opu_pkg::data_t c_reg, s1_reg, s0_reg;
  logic c_fwd, s1_fwd, s0_fwd, d_fwd;
  opu_pkg::data_t c_fwd_val, s1_fwd_val, s0_fwd_val, d_fwd_val;

  assign c_field  = '{num: cmd.num_cond, ptr: cmd.ptr_cond, upd: cmd.upd_cond};
  assign s1_field = '{num: cmd.num_s1, ptr: cmd.ptr_s1, upd: cmd.upd_s1};
  assign s0_field = '{num: cmd.num_s0, ptr: cmd.ptr_s0, upd: cmd.upd_s0};
  assign d_field  = '{num: cmd.num_d, ptr: cmd.ptr_d, upd: cmd.upd_d};
  assign cmd_code = cmd.code;

  // idle slots hold zero on their request lines
  assign s_rd    = c_rd | s1_rd | s0_rd;
  assign s_wr    = c_wr | s1_wr | s0_wr;
  assign s_addr  = c_addr | s1_addr | s0_addr;
  assign s_wdata = c_wdata | s1_wdata | s0_wdata;

  cmd_fetch fetch0 (
    .clk, .rst, .start, .reg_base,
    .grant_done(f_done), .grant_rdata(f_rdata),
    .req_rd(f_rd), .req_wr(f_wr), .req_addr(f_addr), .req_wdata(f_wdata),
    .cmd, .ip_next, .fetch_done
  );

  forward_select fwd0 (
    .cmd, .ip_next, .cond_reg(c_reg), .src1_reg(s1_reg), .src0_reg(s0_reg),
    .cond_fwd(c_fwd), .src1_fwd(s1_fwd), .src0_fwd(s0_fwd), .dst_fwd(d_fwd),
    .cond_fwd_val(c_fwd_val), .src1_fwd_val(s1_fwd_val),
    .src0_fwd_val(s0_fwd_val), .dst_fwd_val(d_fwd_val)
  );

  // cond, src1, src0 chained by done pulses
  operand_slot cond_slot (
    .clk, .rst, .go(fetch_done),
    .base(reg_base + opu_pkg::data_t'(c_field.num)), .field(c_field),
    .fwd_hit(c_fwd), .fwd_val(c_fwd_val), .grant_done(s_done), .grant_rdata(s_rdata),
    .req_rd(c_rd), .req_wr(c_wr), .req_addr(c_addr), .req_wdata(c_wdata),
    .reg_val(c_reg), .operand(cond), .slot_done(c_done)
  );

  operand_slot src1_slot (
    .clk, .rst, .go(c_done),
    .base(reg_base + opu_pkg::data_t'(s1_field.num)), .field(s1_field),
    .fwd_hit(s1_fwd), .fwd_val(s1_fwd_val), .grant_done(s_done), .grant_rdata(s_rdata),
    .req_rd(s1_rd), .req_wr(s1_wr), .req_addr(s1_addr), .req_wdata(s1_wdata),
    .reg_val(s1_reg), .operand(src1), .slot_done(s1_done)
  );

  operand_slot src0_slot (
    .clk, .rst, .go(s1_done),
    .base(reg_base + opu_pkg::data_t'(s0_field.num)), .field(s0_field),
    .fwd_hit(s0_fwd), .fwd_val(s0_fwd_val), .grant_done(s_done), .grant_rdata(s_rdata),
    .req_rd(s0_rd), .req_wr(s0_wr), .req_addr(s0_addr), .req_wdata(s0_wdata),
    .reg_val(s0_reg), .operand(src0), .slot_done(operands_valid)
  );

  dst_writer dst0 (
    .clk, .rst, .result_valid, .result,
    .base(reg_base + opu_pkg::data_t'(d_field.num)), .field(d_field),
    .fwd_hit(d_fwd), .fwd_val(d_fwd_val), .grant_done(d_done), .grant_rdata(d_rdata),
    .req_rd(d_rd), .req_wr(d_wr), .req_addr(d_addr), .req_wdata(d_wdata), .done
  );

  mem_port_mux mux0 (
    .clk, .rst,
    .fetch_req_rd(f_rd), .fetch_req_wr(f_wr),
    .fetch_req_addr(f_addr), .fetch_req_wdata(f_wdata),
    .slot_req_rd(s_rd), .slot_req_wr(s_wr),
    .slot_req_addr(s_addr), .slot_req_wdata(s_wdata),
    .dst_req_rd(d_rd), .dst_req_wr(d_wr),
    .dst_req_addr(d_addr), .dst_req_wdata(d_wdata),
    .mem_rd_done, .mem_wr_done, .mem_rdata,
    .mem_rd, .mem_wr, .mem_addr, .mem_wdata,
    .fetch_grant_done(f_done), .fetch_grant_rdata(f_rdata),
    .slot_grant_done(s_done), .slot_grant_rdata(s_rdata),
    .dst_grant_done(d_done), .dst_grant_rdata(d_rdata)
  );

endmodule

//--- verif/tb_mem.sv
`timescale 1ns/1ps
`include "opu_defs.svh"

module tb_mem (
  input  logic           clk,
  input  logic           rst,
  input  logic           mem_rd,
  input  logic           mem_wr,
  input  opu_pkg::data_t mem_addr,
  input  opu_pkg::data_t mem_wdata,
  output opu_pkg::data_t mem_rdata,
  output logic           mem_rd_done,
  output logic           mem_wr_done,
  output int             read_count
);

  opu_pkg::data_t words [`OPU_MEM_WORDS];
  logic [31:0] rand_state = 32'd1;
  logic busy;
  logic is_read;
  logic [1:0] wait_cnt;
  opu_pkg::data_t addr_q;

  // lcg, upper bits only
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // backdoor load while the port is idle
  task automatic poke(input int unsigned idx, input opu_pkg::data_t value);
    words[idx] = value;
  endtask

  function automatic opu_pkg::data_t peek(input int unsigned idx);
    return words[idx];
  endfunction

  always @(posedge clk) begin
    mem_rd_done <= 1'b0;
    mem_wr_done <= 1'b0;
    if (rst) begin
      busy       <= 1'b0;
      read_count <= 0;
    end else if (busy) begin
      // latency 1 to 4 cycles
      if (wait_cnt == 2'd0) begin
        busy        <= 1'b0;
        mem_rd_done <= is_read;
        mem_wr_done <= !is_read;
        mem_rdata   <= words[addr_q % `OPU_MEM_WORDS];
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end else if (mem_rd || mem_wr) begin
      busy     <= 1'b1;
      is_read  <= mem_rd;
      addr_q   <= mem_addr;
      wait_cnt <= next_rand() >> 30;
      if (mem_rd) read_count <= read_count + 1;
      // write lands at once, done comes later
      if (mem_wr) words[mem_addr % `OPU_MEM_WORDS] = mem_wdata;
    end
  end

endmodule

//--- verif/operand_unit_tb.sv
`timescale 1ns/1ps
`include "opu_defs.svh"

module operand_unit_tb;

  localparam int N_CMDS = 200;
  localparam int CLK_NS = 4;
  // up to 15 memory operations per command, at most 8 cycles each, plus handshakes
  localparam int WATCHDOG_NS = N_CMDS * 20 * 8 * CLK_NS;

  logic clk = 1'b0;
  logic rst;
  logic start;
  opu_pkg::data_t reg_base;
  opu_pkg::data_t result;
  logic result_valid;
  opu_pkg::data_t mem_rdata;
  logic mem_rd_done;
  logic mem_wr_done;
  logic mem_rd;
  logic mem_wr;
  opu_pkg::data_t mem_addr;
  opu_pkg::data_t mem_wdata;
  opu_pkg::data_t cond;
  opu_pkg::data_t src1;
  opu_pkg::data_t src0;
  opu_pkg::cmd_code_t cmd_code;
  logic operands_valid;
  logic done;
  int read_count;

  logic [31:0] rand_state = 32'd1;
  // reference copy of memory
  opu_pkg::data_t model_mem [`OPU_MEM_WORDS];
  // register values already produced by an earlier step
  logic known [16];
  opu_pkg::data_t cached [16];
  opu_pkg::data_t exp_cond;
  opu_pkg::data_t exp_src1;
  opu_pkg::data_t exp_src0;
  opu_pkg::cmd_code_t exp_code;
  int exp_reads;

  always #(CLK_NS / 2) clk = ~clk;

  operand_unit dut0 (
    .clk, .rst, .start, .reg_base, .result, .result_valid,
    .mem_rdata, .mem_rd_done, .mem_wr_done,
    .mem_rd, .mem_wr, .mem_addr, .mem_wdata,
    .cond, .src1, .src0, .cmd_code, .operands_valid, .done
  );

  tb_mem mem0 (
    .clk, .rst, .mem_rd, .mem_wr, .mem_addr, .mem_wdata,
    .mem_rdata, .mem_rd_done, .mem_wr_done, .read_count
  );

  // lcg stepped twice, high halves joined
  function automatic logic [31:0] next_rand();
    logic [15:0] hi;
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    hi = rand_state[31:16];
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return {hi, rand_state[31:16]};
  endfunction

  function automatic int unsigned word_index(input opu_pkg::data_t addr);
    return addr % `OPU_MEM_WORDS;
  endfunction

  // 01 inc, 10 dec, 00 and 11 keep
  function automatic opu_pkg::data_t after_update(input opu_pkg::data_t value,
                                                  input logic [1:0] upd);
    if (upd == 2'b01) return value + 1;
    if (upd == 2'b10) return value - 1;
    return value;
  endfunction

  // pre-update value, forwarded or read
  task automatic model_reg(input opu_pkg::data_t base, input logic [3:0] num,
                           output opu_pkg::data_t pre);
    if (known[num]) begin
      pre = cached[num];
    end else begin
      pre = model_mem[word_index(base + num)];
      exp_reads++;
    end
  endtask

  task automatic model_operand(input opu_pkg::data_t base, input logic [3:0] num,
                               input logic ptr, input logic [1:0] upd,
                               output opu_pkg::data_t operand);
    opu_pkg::data_t pre;
    opu_pkg::data_t post;
    model_reg(base, num, pre);
    if (ptr) begin
      operand = model_mem[word_index(pre)];
      exp_reads++;
    end else begin
      operand = pre;
    end
    post = after_update(pre, upd);
    if (upd == 2'b01 || upd == 2'b10) model_mem[word_index(base + num)] = post;
    known[num]  = 1'b1;
    cached[num] = post;
  endtask

  task automatic run_model(input opu_pkg::data_t rb, input opu_pkg::data_t res);
    opu_pkg::data_t ip;
    opu_pkg::data_t word;
    opu_pkg::data_t pre;
    int r;
    for (r = 0; r < 16; r++) known[r] = 1'b0;
    ip = model_mem[word_index(rb + `OPU_REG_IP)];
    word = model_mem[word_index(ip)];
    exp_reads = 2;
    model_mem[word_index(rb + `OPU_REG_IP)] = ip + 1;
    known[`OPU_REG_IP]  = 1'b1;
    cached[`OPU_REG_IP] = ip + 1;
    exp_code = word[31:28];
    // cond, src1, src0 in that order
    model_operand(rb, word[15:12], word[19], word[27:26], exp_cond);
    model_operand(rb, word[3:0], word[16], word[21:20], exp_src1);
    model_operand(rb, word[7:4], word[17], word[23:22], exp_src0);
    if (!word[18]) begin
      model_mem[word_index(rb + word[11:8])] = res;
    end else begin
      // store through dst, then its own update
      model_reg(rb, word[11:8], pre);
      model_mem[word_index(pre)] = res;
      if (word[25:24] == 2'b01 || word[25:24] == 2'b10)
        model_mem[word_index(rb + word[11:8])] = after_update(pre, word[25:24]);
    end
  endtask

  task automatic check_data(input string name, input opu_pkg::data_t got,
                            input opu_pkg::data_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_code(input string name, input opu_pkg::cmd_code_t got,
                            input opu_pkg::cmd_code_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "code mismatch");
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "count mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "flag mismatch");
    end
  endtask

  initial begin : main_seq
    int n;
    int i;
    int reads_before;
    opu_pkg::data_t rb;
    opu_pkg::data_t res;
    opu_pkg::data_t w;
    rst          = 1'b1;
    start        = 1'b0;
    reg_base     = '0;
    result       = '0;
    result_valid = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    // port and strobes stay quiet until the first start
    repeat (4) begin
      @(negedge clk);
      check_flag("mem_rd", mem_rd, 1'b0);
      check_flag("mem_wr", mem_wr, 1'b0);
      check_flag("operands_valid", operands_valid, 1'b0);
      check_flag("done", done, 1'b0);
    end
    for (n = 0; n < N_CMDS; n++) begin
      rb  = next_rand();
      res = next_rand();
      for (i = 0; i < `OPU_MEM_WORDS; i++) begin
        w = next_rand();
        model_mem[i] = w;
        mem0.poke(i, w);
      end
      run_model(rb, res);
      reads_before = read_count;
      @(posedge clk);
      reg_base <= rb;
      start    <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
      while (operands_valid !== 1'b1) @(negedge clk);
      check_data("cond", cond, exp_cond);
      check_data("src1", src1, exp_src1);
      check_data("src0", src0, exp_src0);
      check_code("cmd_code", cmd_code, exp_code);
      @(posedge clk);
      result       <= res;
      result_valid <= 1'b1;
      @(posedge clk);
      result_valid <= 1'b0;
      @(negedge clk);
      while (done !== 1'b1) @(negedge clk);
      // forwarded registers must not be read again
      check_count("read_count", read_count - reads_before, exp_reads);
      for (i = 0; i < `OPU_MEM_WORDS; i++) begin
        check_data($sformatf("mem[%0d]", i), mem0.peek(i), model_mem[i]);
      end
    end
    $display("*** PASSED ***");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns with commands still running", WATCHDOG_NS);
    $display("*** FAILED ***");
    $fatal(1, "timeout");
  end

endmodule

//--- operand_unit.f
+incdir+include
rtl/opu_pkg.sv
rtl/cmd_fetch.sv
rtl/forward_select.sv
rtl/operand_slot.sv
rtl/dst_writer.sv
rtl/mem_port_mux.sv
rtl/operand_unit.sv
verif/tb_mem.sv
verif/operand_unit_tb.sv
